/* hw/cave_config.svh */
////////////////////////////////////////////////////////////
// Widths, reset timing and status bit positions for the control block
// Scan codes are PS/2 set 2 make codes without the E0 prefix
////////////////////////////////////////////////////////////
`ifndef CAVE_CONFIG_SVH
`define CAVE_CONFIG_SVH

// Host word widths
`define CAVE_STATUS_W 32
`define CAVE_JOY_W 32
// Toggle at bit 10, pressed at bit 9, scan code in 7:0
`define CAVE_PS2_W 11

// Reset timing in clk_sys cycles
`define CAVE_PLL_RST_CYCLES 256
`define CAVE_RESET_STAGES 2

// Menu status bit positions
`define CAVE_ST_RESET 0
`define CAVE_ST_WIDE 1
`define CAVE_ST_ROTATE 2
`define CAVE_ST_FLIP 3
`define CAVE_ST_FX_LO 4
`define CAVE_ST_COMPAT 7
`define CAVE_ST_DISABLE_LO 10
`define CAVE_ST_GAME_LO 18
`define CAVE_ST_OFFX_LO 24
`define CAVE_ST_OFFY_LO 28

// Mapped keyboard scan codes
`define CAVE_KEY_UP 8'h75
`define CAVE_KEY_DOWN 8'h72
`define CAVE_KEY_LEFT 8'h6B
`define CAVE_KEY_RIGHT 8'h74
`define CAVE_KEY_CTRL 8'h14
`define CAVE_KEY_ALT 8'h11
`define CAVE_KEY_SHIFT 8'h12
`define CAVE_KEY_SPACE 8'h29
`define CAVE_KEY_1 8'h16
`define CAVE_KEY_2 8'h1E
`define CAVE_KEY_5 8'h2E
`define CAVE_KEY_6 8'h36
`define CAVE_KEY_9 8'h46
`define CAVE_KEY_0 8'h45
`define CAVE_KEY_A 8'h1C
`define CAVE_KEY_S 8'h1B
`define CAVE_KEY_Q 8'h15
`define CAVE_KEY_R 8'h2D
`define CAVE_KEY_F 8'h2B
`define CAVE_KEY_D 8'h23
`define CAVE_KEY_G 8'h34
`define CAVE_KEY_P 8'h4D
`define CAVE_KEY_W 8'h1D

`endif

/* hw/cave_control_top.sv */
////////////////////////////////////////////////////////////
// Control front end of the arcade core, single clk_sys domain
// All inputs are expected synchronous to clk_sys except RESET
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module cave_control_top (
  input  logic                       clk_sys,
  input  logic                       RESET,
  input  logic                       pll_locked,
  input  logic [`CAVE_PS2_W-1:0]     ps2_key,
  input  logic [`CAVE_JOY_W-1:0]     joystick_0,
  input  logic [`CAVE_JOY_W-1:0]     joystick_1,
  input  logic [`CAVE_STATUS_W-1:0]  status,
  input  logic                       forced_scandoubler,
  input  logic                       user_reset,
  output logic                       rst_pll,
  output logic                       rst_sys,
  output logic                       rst_cpu,
  output cave_pkg::player_inputs_t   players,
  output cave_pkg::options_t         options,
  output cave_pkg::video_mode_t      video_mode
);

  import cave_pkg::*;

  logic       sys_reset_in;
  logic       cpu_reset_in;
  key_state_t keys;

  ////////////////////////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////////////////////////
  // System held while PLL is unlocked
  assign sys_reset_in = RESET | ~pll_locked;
  // CPU also follows menu reset and host button
  assign cpu_reset_in = sys_reset_in | status[`CAVE_ST_RESET] | user_reset;

  pll_reset_supervisor u_pll_sup (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .rst_pll    (rst_pll)
  );

  reset_sync u_sys_sync (
    .clk_sys   (clk_sys),
    .reset_in  (sys_reset_in),
    .reset_out (rst_sys)
  );

  reset_sync u_cpu_sync (
    .clk_sys   (clk_sys),
    .reset_in  (cpu_reset_in),
    .reset_out (rst_cpu)
  );

  ////////////////////////////////////////////////////////////
  // Controls and options
  ////////////////////////////////////////////////////////////
  ps2_key_tracker u_keys (
    .clk_sys (clk_sys),
    .RESET   (rst_sys),
    .ps2_key (ps2_key),
    .keys    (keys)
  );

  player_input_merge u_merge (
    .clk_sys    (clk_sys),
    .RESET      (rst_sys),
    .keys       (keys),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .players    (players)
  );

  option_decoder u_options (
    .clk_sys            (clk_sys),
    .RESET              (rst_sys),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .options            (options),
    .video_mode         (video_mode)
  );

endmodule

`default_nettype wire

/* hw/cave_pkg.sv */
////////////////////////////////////////////////////////////
// Packed types for player inputs, game options and video mode
// Field order is MSB first as declared
////////////////////////////////////////////////////////////
`default_nettype none

package cave_pkg;

  // Held key state, one bit per mapped scan code
  typedef struct packed {
    logic key_up;
    logic key_down;
    logic key_left;
    logic key_right;
    logic key_ctrl;
    logic key_alt;
    logic key_shift;
    logic key_space;
    logic key_1;
    logic key_2;
    logic key_5;
    logic key_6;
    logic key_9;
    logic key_0;
    logic key_a;
    logic key_s;
    logic key_q;
    logic key_r;
    logic key_f;
    logic key_d;
    logic key_g;
    logic key_p;
    logic key_w;
  } key_state_t;

  // One player, button 4 in the top bit of buttons
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
  } player_t;

  typedef struct packed {
    player_t player_1;
    player_t player_2;
    logic    service_1;
    logic    service_2;
  } player_inputs_t;

  // Game options, enables are active high
  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compatibility;
    logic       en_sprite;
    logic       en_layer_0;
    logic       en_layer_1;
    logic       en_layer_2;
    logic       en_row_scroll;
    logic       en_row_select;
    logic       en_fb_sprite;
    logic       en_fb_system;
    logic [3:0] game_index;
  } options_t;

  // HDMI aspect ratio and scaler controls
  typedef struct packed {
    logic [12:0] arx;
    logic [12:0] ary;
    logic [1:0]  scanline;
    logic        scandoubler;
    logic        hq2x;
  } video_mode_t;

endpackage

`default_nettype wire

/* hw/option_decoder.sv */
////////////////////////////////////////////////////////////
// Decodes the menu status word into options and video mode
// fx codes above 4 have no menu entry
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module option_decoder (
  input  logic                       clk_sys,
  input  logic                       RESET,
  input  logic [`CAVE_STATUS_W-1:0]  status,
  input  logic                       forced_scandoubler,
  output cave_pkg::options_t         options,
  output cave_pkg::video_mode_t      video_mode
);

  import cave_pkg::*;

  logic [2:0]  fx;
  logic [2:0]  fx_m1;
  logic [7:0]  disables;
  options_t    options_next;
  video_mode_t video_next;

  assign fx       = status[`CAVE_ST_FX_LO +: 3];
  assign fx_m1    = fx - 3'd1;
  assign disables = status[`CAVE_ST_DISABLE_LO +: 8];

  ////////////////////////////////////////////////////////////
  // Game options
  ////////////////////////////////////////////////////////////
  always_comb begin
    options_next.offset_x      = status[`CAVE_ST_OFFX_LO +: 4];
    options_next.offset_y      = status[`CAVE_ST_OFFY_LO +: 4];
    options_next.rotate        = status[`CAVE_ST_ROTATE];
    options_next.flip          = status[`CAVE_ST_FLIP];
    options_next.compatibility = status[`CAVE_ST_COMPAT];
    // Menu bits are disables, core wants enables
    options_next.en_sprite     = ~disables[0];
    options_next.en_layer_0    = ~disables[1];
    options_next.en_layer_1    = ~disables[2];
    options_next.en_layer_2    = ~disables[3];
    options_next.en_row_scroll = ~disables[4];
    options_next.en_row_select = ~disables[5];
    options_next.en_fb_sprite  = ~disables[6];
    options_next.en_fb_system  = ~disables[7];
    options_next.game_index    = status[`CAVE_ST_GAME_LO +: 4];
  end

  ////////////////////////////////////////////////////////////
  // Video mode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Wide beats rotate
    if (status[`CAVE_ST_WIDE]) begin
      video_next.arx = 13'd16;
      video_next.ary = 13'd9;
    end else if (status[`CAVE_ST_ROTATE]) begin
      video_next.arx = 13'd3;
      video_next.ary = 13'd4;
    end else begin
      video_next.arx = 13'd4;
      video_next.ary = 13'd3;
    end
    // fx 2..4 map to CRT 25, 50 and 75 percent
    video_next.scanline    = (fx != 3'd0) ? fx_m1[1:0] : 2'd0;
    video_next.scandoubler = (fx != 3'd0) || forced_scandoubler;
    video_next.hq2x        = fx == 3'd1;
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      options    <= '0;
      video_mode <= '0;
    end else begin
      options    <= options_next;
      video_mode <= video_next;
    end
  end

  a_fx_range : assert property (
    @(posedge clk_sys) disable iff (RESET) fx <= 3'd4
  );

endmodule

`default_nettype wire

/* hw/player_input_merge.sv */
////////////////////////////////////////////////////////////
// Registered OR of keyboard and joystick into player inputs
// Player 2 pause has no key and comes from the joystick only
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module player_input_merge (
  input  logic                        clk_sys,
  input  logic                        RESET,
  input  cave_pkg::key_state_t        keys,
  input  logic [`CAVE_JOY_W-1:0]      joystick_0,
  input  logic [`CAVE_JOY_W-1:0]      joystick_1,
  output cave_pkg::player_inputs_t    players
);

  import cave_pkg::*;

  localparam int JOY_SERVICE = 11;

  player_t        key_p1;
  player_t        key_p2;
  player_inputs_t players_next;

  // Joystick bits 10 down to 0 into player order
  function automatic player_t joy_to_player(input logic [`CAVE_JOY_W-1:0] joy);
    player_t p;
    p.right   = joy[0];
    p.left    = joy[1];
    p.down    = joy[2];
    p.up      = joy[3];
    p.buttons = joy[7:4];
    p.start   = joy[8];
    p.coin    = joy[9];
    p.pause   = joy[10];
    return p;
  endfunction

  // Keyboard layouts of both players
  assign key_p1 = '{up: keys.key_up, down: keys.key_down, left: keys.key_left,
                    right: keys.key_right,
                    buttons: {keys.key_shift, keys.key_space, keys.key_alt, keys.key_ctrl},
                    start: keys.key_1, coin: keys.key_5, pause: keys.key_p};
  assign key_p2 = '{up: keys.key_r, down: keys.key_f, left: keys.key_d,
                    right: keys.key_g,
                    buttons: {keys.key_w, keys.key_q, keys.key_s, keys.key_a},
                    start: keys.key_2, coin: keys.key_6, pause: 1'b0};

  always_comb begin
    players_next.player_1  = player_t'(key_p1 | joy_to_player(joystick_0));
    players_next.player_2  = player_t'(key_p2 | joy_to_player(joystick_1));
    players_next.service_1 = keys.key_9 | joystick_0[JOY_SERVICE];
    players_next.service_2 = keys.key_0 | joystick_1[JOY_SERVICE];
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      players <= '0;
    end else begin
      players <= players_next;
    end
  end

endmodule

`default_nettype wire

/* hw/pll_reset_supervisor.sv */
////////////////////////////////////////////////////////////
// Holds the PLL reset after a falling lock for a fixed cycle count
// pll_locked must already be synchronous to clk_sys
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module pll_reset_supervisor (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic rst_pll
);

  localparam int CNT_W = $clog2(`CAVE_PLL_RST_CYCLES);

  logic             locked_q;
  logic [CNT_W-1:0] count;

  // Lock was high last edge and is low now
  logic lock_lost;
  assign lock_lost = locked_q && !pll_locked;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      locked_q <= 1'b0;
      count    <= '0;
      rst_pll  <= 1'b0;
    end else begin
      locked_q <= pll_locked;
      if (lock_lost) begin
        // Restart the pulse, also mid pulse
        count   <= CNT_W'(`CAVE_PLL_RST_CYCLES - 1);
        rst_pll <= 1'b1;
      end else if (count != '0) begin
        count <= count - 1'b1;
      end else begin
        rst_pll <= 1'b0;
      end
    end
  end

  // Pulse covers the whole countdown
  a_rst_during_count : assert property (
    @(posedge clk_sys) disable iff (RESET) (count != '0) |-> rst_pll
  );

endmodule

`default_nettype wire

/* hw/ps2_key_tracker.sv */
////////////////////////////////////////////////////////////
// Held key state from the toggle strobed PS/2 key word
// Extended prefix is ignored and unmapped codes are dropped
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module ps2_key_tracker (
  input  logic                    clk_sys,
  input  logic                    RESET,
  input  logic [`CAVE_PS2_W-1:0]  ps2_key,
  output cave_pkg::key_state_t    keys
);

  import cave_pkg::*;

  // PS/2 word layout
  localparam int TOGGLE_BIT  = `CAVE_PS2_W - 1;
  localparam int PRESSED_BIT = `CAVE_PS2_W - 2;

  logic       toggle_q;
  logic       ps2_event;
  logic       pressed;
  logic [7:0] code;
  key_state_t keys_next;

  assign pressed = ps2_key[PRESSED_BIT];
  assign code    = ps2_key[7:0];

  // New event on any toggle change
  assign ps2_event = ps2_key[TOGGLE_BIT] != toggle_q;

  ////////////////////////////////////////////////////////////
  // Scan code decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    keys_next = keys;
    if (ps2_event) begin
      case (code)
        `CAVE_KEY_UP:    keys_next.key_up    = pressed;
        `CAVE_KEY_DOWN:  keys_next.key_down  = pressed;
        `CAVE_KEY_LEFT:  keys_next.key_left  = pressed;
        `CAVE_KEY_RIGHT: keys_next.key_right = pressed;
        `CAVE_KEY_CTRL:  keys_next.key_ctrl  = pressed;
        `CAVE_KEY_ALT:   keys_next.key_alt   = pressed;
        `CAVE_KEY_SHIFT: keys_next.key_shift = pressed;
        `CAVE_KEY_SPACE: keys_next.key_space = pressed;
        `CAVE_KEY_1:     keys_next.key_1     = pressed;
        `CAVE_KEY_2:     keys_next.key_2     = pressed;
        `CAVE_KEY_5:     keys_next.key_5     = pressed;
        `CAVE_KEY_6:     keys_next.key_6     = pressed;
        `CAVE_KEY_9:     keys_next.key_9     = pressed;
        `CAVE_KEY_0:     keys_next.key_0     = pressed;
        `CAVE_KEY_A:     keys_next.key_a     = pressed;
        `CAVE_KEY_S:     keys_next.key_s     = pressed;
        `CAVE_KEY_Q:     keys_next.key_q     = pressed;
        `CAVE_KEY_R:     keys_next.key_r     = pressed;
        `CAVE_KEY_F:     keys_next.key_f     = pressed;
        `CAVE_KEY_D:     keys_next.key_d     = pressed;
        `CAVE_KEY_G:     keys_next.key_g     = pressed;
        `CAVE_KEY_P:     keys_next.key_p     = pressed;
        `CAVE_KEY_W:     keys_next.key_w     = pressed;
        // Unmapped code, state kept
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q <= 1'b0;
      keys     <= '0;
    end else begin
      toggle_q <= ps2_key[TOGGLE_BIT];
      keys     <= keys_next;
    end
  end

  // An unknown toggle would fake or hide events
  a_toggle_known : assert property (
    @(posedge clk_sys) disable iff (RESET) !$isunknown(ps2_key[TOGGLE_BIT])
  );

endmodule

`default_nettype wire

/* hw/reset_sync.sv */
////////////////////////////////////////////////////////////
// Asynchronous assert, synchronous release of a reset
// reset_in may come from any domain or combinational logic
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module reset_sync (
  input  logic clk_sys,
  input  logic reset_in,
  output logic reset_out
);

  localparam int STAGES = `CAVE_RESET_STAGES;

  // Chain of flops, all set while reset_in is high
  logic [STAGES-1:0] sync_chain;

  always_ff @(posedge clk_sys or posedge reset_in) begin
    if (reset_in) begin
      sync_chain <= '1;
    end else begin
      // Zeros walk towards the output
      sync_chain <= sync_chain << 1;
    end
  end

  // Last stage drives the synchronized reset
  assign reset_out = sync_chain[STAGES-1];

  // Output may never release ahead of its source
  a_no_early_release : assert property (
    @(posedge clk_sys) reset_in |-> reset_out
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the control block testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_cave_control -o sim_tb

# The run itself may stop with an error status, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

/* src.f */
+incdir+hw
hw/cave_pkg.sv
hw/pll_reset_supervisor.sv
hw/reset_sync.sv
hw/ps2_key_tracker.sv
hw/player_input_merge.sv
hw/option_decoder.sv
hw/cave_control_top.sv
verification/tb_cave_control.sv

/* verification/tb_cave_control.sv */
////////////////////////////////////////////////////////////
// Random stimulus on the falling clk_sys edge from a fixed seed
// Reference model tracks key state, output latency and resets
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "cave_config.svh"

module tb_cave_control;

  import cave_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int N_PS2        = 200;
  localparam int N_JOY        = 150;
  localparam int N_STATUS     = 150;
  localparam int N_FLICKER    = 60;
  localparam int N_PLL_WAIT   = 300;
  localparam int TOTAL_CYCLES = 4 + N_PS2 + N_JOY + N_STATUS + N_FLICKER + 2 * N_PLL_WAIT + 100;
  localparam int KEY_W        = $bits(key_state_t);
  localparam int TOG          = `CAVE_PS2_W - 1;
  localparam int PRS          = `CAVE_PS2_W - 2;

  logic                      clk_sys = 1'b0;
  logic                      RESET;
  logic                      pll_locked;
  logic [`CAVE_PS2_W-1:0]    ps2_key;
  logic [`CAVE_JOY_W-1:0]    joystick_0;
  logic [`CAVE_JOY_W-1:0]    joystick_1;
  logic [`CAVE_STATUS_W-1:0] status;
  logic                      forced_scandoubler;
  logic                      user_reset;
  logic                      rst_pll;
  logic                      rst_sys;
  logic                      rst_cpu;
  player_inputs_t            players;
  options_t                  options;
  video_mode_t               video_mode;

  integer seed      = 32'hb6ec;
  int     err_count = 0;

  // Reference model state
  key_state_t     m_keys;
  logic           m_toggle;
  logic           m_lock_q;
  int             m_pll_left;
  int             m_sys_cnt;
  int             m_cpu_cnt;
  player_inputs_t exp_players;
  options_t       exp_options;
  video_mode_t    exp_video;

  cave_control_top DUT (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .pll_locked         (pll_locked),
    .ps2_key            (ps2_key),
    .joystick_0         (joystick_0),
    .joystick_1         (joystick_1),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .user_reset         (user_reset),
    .rst_pll            (rst_pll),
    .rst_sys            (rst_sys),
    .rst_cpu            (rst_cpu),
    .players            (players),
    .options            (options),
    .video_mode         (video_mode)
  );

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////
  // Scan code of each key_state_t bit, MSB is up
  function automatic logic [7:0] key_code(input int pos);
    case (pos)
      22: return `CAVE_KEY_UP;
      21: return `CAVE_KEY_DOWN;
      20: return `CAVE_KEY_LEFT;
      19: return `CAVE_KEY_RIGHT;
      18: return `CAVE_KEY_CTRL;
      17: return `CAVE_KEY_ALT;
      16: return `CAVE_KEY_SHIFT;
      15: return `CAVE_KEY_SPACE;
      14: return `CAVE_KEY_1;
      13: return `CAVE_KEY_2;
      12: return `CAVE_KEY_5;
      11: return `CAVE_KEY_6;
      10: return `CAVE_KEY_9;
      9:  return `CAVE_KEY_0;
      8:  return `CAVE_KEY_A;
      7:  return `CAVE_KEY_S;
      6:  return `CAVE_KEY_Q;
      5:  return `CAVE_KEY_R;
      4:  return `CAVE_KEY_F;
      3:  return `CAVE_KEY_D;
      2:  return `CAVE_KEY_G;
      1:  return `CAVE_KEY_P;
      0:  return `CAVE_KEY_W;
      default: return 8'h00;
    endcase
  endfunction

  // Bit position of a code, -1 when not mapped
  function automatic int key_bit(input logic [7:0] code);
    for (int pos = 0; pos < KEY_W; pos++) begin
      if (key_code(pos) == code) begin
        return pos;
      end
    end
    return -1;
  endfunction

  function automatic player_inputs_t ref_players(input key_state_t k,
                                                 input logic [`CAVE_JOY_W-1:0] j0,
                                                 input logic [`CAVE_JOY_W-1:0] j1);
    player_inputs_t p;
    p.player_1.right      = k.key_right | j0[0];
    p.player_1.left       = k.key_left  | j0[1];
    p.player_1.down       = k.key_down  | j0[2];
    p.player_1.up         = k.key_up    | j0[3];
    p.player_1.buttons[0] = k.key_ctrl  | j0[4];
    p.player_1.buttons[1] = k.key_alt   | j0[5];
    p.player_1.buttons[2] = k.key_space | j0[6];
    p.player_1.buttons[3] = k.key_shift | j0[7];
    p.player_1.start      = k.key_1     | j0[8];
    p.player_1.coin       = k.key_5     | j0[9];
    p.player_1.pause      = k.key_p     | j0[10];
    p.player_2.right      = k.key_g     | j1[0];
    p.player_2.left       = k.key_d     | j1[1];
    p.player_2.down       = k.key_f     | j1[2];
    p.player_2.up         = k.key_r     | j1[3];
    p.player_2.buttons[0] = k.key_a     | j1[4];
    p.player_2.buttons[1] = k.key_s     | j1[5];
    p.player_2.buttons[2] = k.key_q     | j1[6];
    p.player_2.buttons[3] = k.key_w     | j1[7];
    p.player_2.start      = k.key_2     | j1[8];
    p.player_2.coin       = k.key_6     | j1[9];
    // No pause key for player 2
    p.player_2.pause      = j1[10];
    p.service_1           = k.key_9     | j0[11];
    p.service_2           = k.key_0     | j1[11];
    return p;
  endfunction

  function automatic options_t ref_options(input logic [`CAVE_STATUS_W-1:0] st);
    options_t o;
    o.offset_x      = st[`CAVE_ST_OFFX_LO +: 4];
    o.offset_y      = st[`CAVE_ST_OFFY_LO +: 4];
    o.rotate        = st[`CAVE_ST_ROTATE];
    o.flip          = st[`CAVE_ST_FLIP];
    o.compatibility = st[`CAVE_ST_COMPAT];
    {o.en_fb_system, o.en_fb_sprite, o.en_row_select, o.en_row_scroll,
     o.en_layer_2, o.en_layer_1, o.en_layer_0, o.en_sprite} = ~st[`CAVE_ST_DISABLE_LO +: 8];
    o.game_index    = st[`CAVE_ST_GAME_LO +: 4];
    return o;
  endfunction

  function automatic video_mode_t ref_video(input logic [`CAVE_STATUS_W-1:0] st,
                                            input logic fsd);
    video_mode_t v;
    logic [2:0]  fx;
    fx = st[`CAVE_ST_FX_LO +: 3];
    v  = '0;
    if (st[`CAVE_ST_WIDE]) begin
      v.arx = 13'd16;
      v.ary = 13'd9;
    end else if (st[`CAVE_ST_ROTATE]) begin
      v.arx = 13'd3;
      v.ary = 13'd4;
    end else begin
      v.arx = 13'd4;
      v.ary = 13'd3;
    end
    // Scanline table per fx menu entry
    case (fx)
      3'd2:    v.scanline = 2'd1;
      3'd3:    v.scanline = 2'd2;
      3'd4:    v.scanline = 2'd3;
      default: v.scanline = 2'd0;
    endcase
    v.scandoubler = (fx != 3'd0) | fsd;
    v.hq2x        = (fx == 3'd1);
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic stop_on_mismatch(input string msg);
    err_count++;
    $display("FAILED at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic check_players(input player_inputs_t exp, input player_inputs_t act,
                               input string tag);
    if (act !== exp) begin
      stop_on_mismatch($sformatf("players %s expected %h got %h", tag, exp, act));
    end
  endtask

  task automatic check_options(input options_t exp, input options_t act, input string tag);
    if (act !== exp) begin
      stop_on_mismatch($sformatf("options %s expected %h got %h", tag, exp, act));
    end
  endtask

  task automatic check_video(input video_mode_t exp, input video_mode_t act,
                             input string tag);
    if (act !== exp) begin
      stop_on_mismatch($sformatf("video_mode %s expected %h got %h", tag, exp, act));
    end
  endtask

  // Bit order is pll, sys, cpu
  task automatic check_resets(input logic [2:0] exp, input logic [2:0] act, input string tag);
    if (act !== exp) begin
      stop_on_mismatch($sformatf("resets %s expected %b got %b", tag, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model step and clocking
  ////////////////////////////////////////////////////////////
  task automatic model_edge();
    logic             sys_in;
    logic             cpu_in;
    logic             held;
    int               pos;
    logic [KEY_W-1:0] kv;
    logic [KEY_W-1:0] mask;
    sys_in = RESET | ~pll_locked;
    cpu_in = sys_in | status[`CAVE_ST_RESET] | user_reset;
    // rst_sys level seen by the registers at this edge
    held   = sys_in | (m_sys_cnt != 0);
    if (held) begin
      m_keys      = '0;
      m_toggle    = 1'b0;
      exp_players = '0;
      exp_options = '0;
      exp_video   = '0;
    end else begin
      // Merge register sees key state from before this edge
      exp_players = ref_players(m_keys, joystick_0, joystick_1);
      if (ps2_key[TOG] != m_toggle) begin
        pos = key_bit(ps2_key[7:0]);
        if (pos >= 0) begin
          kv     = m_keys;
          mask   = KEY_W'(1) << pos;
          kv     = ps2_key[PRS] ? (kv | mask) : (kv & ~mask);
          m_keys = kv;
        end
      end
      m_toggle    = ps2_key[TOG];
      exp_options = ref_options(status);
      exp_video   = ref_video(status, forced_scandoubler);
    end
    // PLL reset pulse length in remaining edges
    if (RESET) begin
      m_lock_q   = 1'b0;
      m_pll_left = 0;
    end else begin
      if (m_lock_q && !pll_locked) begin
        m_pll_left = `CAVE_PLL_RST_CYCLES;
      end else if (m_pll_left > 0) begin
        m_pll_left--;
      end
      m_lock_q = pll_locked;
    end
    m_sys_cnt = sys_in ? `CAVE_RESET_STAGES : ((m_sys_cnt > 0) ? m_sys_cnt - 1 : 0);
    m_cpu_cnt = cpu_in ? `CAVE_RESET_STAGES : ((m_cpu_cnt > 0) ? m_cpu_cnt - 1 : 0);
  endtask

  // One edge, then compare on the falling edge
  task automatic tick();
    @(posedge clk_sys);
    model_edge();
    @(negedge clk_sys);
    check_resets({m_pll_left != 0, m_sys_cnt != 0, m_cpu_cnt != 0},
                 {rst_pll, rst_sys, rst_cpu}, "per cycle");
    check_players(exp_players, players, "per cycle");
    check_options(exp_options, options, "per cycle");
    check_video(exp_video, video_mode, "per cycle");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic send_ps2_event(input logic [7:0] code, input logic pressed);
    ps2_key = {~ps2_key[TOG], pressed, 1'b0, code};
  endtask

  // Toggle back to 0 with an unmapped code
  task automatic park_ps2();
    if (ps2_key[TOG]) begin
      ps2_key = {1'b0, 2'b00, 8'h00};
    end
  endtask

  task automatic drive_random_ps2();
    int         r;
    int         sel;
    logic [7:0] code;
    r   = $random(seed);
    sel = int'($unsigned($random(seed)) % 23);
    if (r[0]) begin
      // Mostly mapped codes
      code    = (r[2:1] == 2'b00) ? r[15:8] : key_code(sel);
      ps2_key = {~ps2_key[TOG], r[16], r[17], code};
    end else begin
      // Toggle kept, other bits scrambled
      ps2_key = {ps2_key[TOG], r[25:16]};
    end
  endtask

  task automatic drive_random_status();
    int r;
    status = $random(seed);
    r      = $random(seed);
    status[`CAVE_ST_FX_LO +: 3] = 3'($unsigned(r) % 5);
    forced_scandoubler = r[8];
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////
  initial begin : watchdog
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Simulation timed out before all tests finished");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    int r;
    int high_cycles;
    RESET              = 1'b1;
    pll_locked         = 1'b1;
    ps2_key            = '0;
    joystick_0         = '0;
    joystick_1         = '0;
    status             = '0;
    forced_scandoubler = 1'b0;
    user_reset         = 1'b0;
    m_keys             = '0;
    m_toggle           = 1'b0;
    m_lock_q           = 1'b0;
    m_pll_left         = 0;
    m_sys_cnt          = `CAVE_RESET_STAGES;
    m_cpu_cnt          = `CAVE_RESET_STAGES;
    exp_players        = '0;
    exp_options        = '0;
    exp_video          = '0;

    // Reset release with the PLL locked
    repeat (4) tick();
    RESET = 1'b0;
    tick();
    check_resets(3'b011, {rst_pll, rst_sys, rst_cpu}, "one edge after RESET");
    tick();
    check_resets(3'b000, {rst_pll, rst_sys, rst_cpu}, "two edges after RESET");
    check_players('0, players, "after RESET");
    check_options('0, options, "after RESET");
    check_video('0, video_mode, "after RESET");

    // PS/2 events only
    for (int i = 0; i < N_PS2; i++) begin
      drive_random_ps2();
      tick();
    end

    // Joysticks over held keys
    for (int i = 0; i < N_JOY; i++) begin
      r          = $random(seed);
      joystick_0 = $random(seed);
      joystick_1 = $random(seed);
      if (r[0]) begin
        drive_random_ps2();
      end
      tick();
    end

    // Status decode
    for (int i = 0; i < N_STATUS; i++) begin
      drive_random_status();
      joystick_0 = $random(seed);
      joystick_1 = $random(seed);
      tick();
    end
    status[`CAVE_ST_RESET] = 1'b0;

    // Lock loss with a held key
    joystick_0 = '0;
    joystick_1 = '0;
    send_ps2_event(`CAVE_KEY_UP, 1'b1);
    tick();
    park_ps2();
    tick();
    tick();
    pll_locked  = 1'b0;
    high_cycles = 0;
    for (int i = 0; i < N_PLL_WAIT; i++) begin
      if (i == 20) begin
        pll_locked = 1'b1;
      end
      tick();
      if (rst_pll) begin
        high_cycles++;
      end
      if (i == 20 || i == 21) begin
        check_resets({1'b1, i == 20, i == 20}, {rst_pll, rst_sys, rst_cpu}, "after relock");
      end
      if (i == 22) begin
        check_players('0, players, "keys cleared by lock loss");
      end
    end
    if (high_cycles != `CAVE_PLL_RST_CYCLES) begin
      stop_on_mismatch($sformatf("rst_pll high for %0d cycles, expected %0d",
                                 high_cycles, `CAVE_PLL_RST_CYCLES));
    end

    // Lock flicker restarts the pulse
    for (int i = 0; i < N_FLICKER; i++) begin
      r          = $random(seed);
      pll_locked = (r[1:0] != 2'b00);
      joystick_0 = $random(seed);
      drive_random_ps2();
      tick();
    end
    pll_locked = 1'b1;
    for (int i = 0; i < N_PLL_WAIT; i++) begin
      joystick_1 = $random(seed);
      drive_random_ps2();
      tick();
    end

    // CPU reset from the menu bit, then the host button
    status[`CAVE_ST_RESET] = 1'b1;
    tick();
    check_resets(3'b001, {rst_pll, rst_sys, rst_cpu}, "menu reset set");
    repeat (4) tick();
    status[`CAVE_ST_RESET] = 1'b0;
    tick();
    check_resets(3'b001, {rst_pll, rst_sys, rst_cpu}, "menu reset cleared one edge");
    tick();
    check_resets(3'b000, {rst_pll, rst_sys, rst_cpu}, "menu reset cleared two edges");
    user_reset = 1'b1;
    tick();
    check_resets(3'b001, {rst_pll, rst_sys, rst_cpu}, "user reset set");
    repeat (4) tick();
    user_reset = 1'b0;
    tick();
    check_resets(3'b001, {rst_pll, rst_sys, rst_cpu}, "user reset cleared one edge");
    tick();
    check_resets(3'b000, {rst_pll, rst_sys, rst_cpu}, "user reset cleared two edges");
    repeat (4) tick();

    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
